//--- include/camera_pkg.sv
package camera_pkg;

   // stored frame geometry
   localparam int FRAME_W   = 320;
   localparam int FRAME_H   = 180;
   localparam int FB_DEPTH  = FRAME_W * FRAME_H;
   // 57600 words need 16 address bits
   localparam int FB_ADDR_W = $clog2(FB_DEPTH);

   // raster count widths, shared by camera and drawing side
   localparam int HCOUNT_W = 11;
   localparam int VCOUNT_W = 10;

   // inclusive window on the widened red channel
   localparam logic [7:0] RED_LOWER = 8'hA0;
   localparam logic [7:0] RED_UPPER = 8'hF0;

   // drawing raster is the frame scaled up by 4 in each direction
   localparam int SCALE_SHIFT = 2;
   localparam int DRAW_W      = 1280;
   localparam int DRAW_H      = 720;

   // centroid arithmetic, 319 * 57600 still fits 26 bits
   localparam int SUM_W = 26;
   localparam int CNT_W = 16;

   // display selector codes
   localparam logic [1:0] MODE_CAMERA    = 2'd0;
   localparam logic [1:0] MODE_MASK      = 2'd1;
   localparam logic [1:0] MODE_CROSSHAIR = 2'd2;
   localparam logic [1:0] MODE_HIGHLIGHT = 2'd3;

   localparam logic [15:0] WHITE_PIXEL = 16'hFFFF;
   localparam logic [15:0] RED_PIXEL   = 16'hF800;

   typedef struct packed {
      logic [4:0] red;
      logic [5:0] green;
      logic [4:0] blue;
   } rgb565_t;

   // one 16-bit word, seen either whole or split into colour fields
   typedef union packed {
      logic [15:0] raw;
      rgb565_t     rgb;
   } pixel_u;

endpackage

//--- hw/mask_threshold.sv
`timescale 1ns/1ps

module mask_threshold import camera_pkg::*; (
   input  logic                clk_camera,
   input  logic                sys_rst_camera,
   input  logic                pixel_valid_i,
   input  logic [HCOUNT_W-1:0] pixel_hcount_i,
   input  logic [VCOUNT_W-1:0] pixel_vcount_i,
   input  pixel_u              pixel_data_i,
   output logic                mask_valid_o,
   output logic [HCOUNT_W-1:0] mask_hcount_o,
   output logic [VCOUNT_W-1:0] mask_vcount_o,
   output pixel_u              mask_pixel_o,
   output logic                mask_bit_o
);

   // red field padded with zeros to the 8-bit threshold scale
   logic [7:0] red_wide;

   assign red_wide = {pixel_data_i.rgb.red, 3'b000};

   // strobe only, cleared by reset
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         mask_valid_o <= 1'b0;
      end else begin
         mask_valid_o <= pixel_valid_i;
      end
   end

   // pixel payload and its counts ride along one stage
   always_ff @(posedge clk_camera) begin
      mask_hcount_o <= pixel_hcount_i;
      mask_vcount_o <= pixel_vcount_i;
      mask_pixel_o  <= pixel_data_i;
      // both bounds inclusive
      mask_bit_o    <= (red_wide >= RED_LOWER) && (red_wide <= RED_UPPER);
   end

   // upstream raster must stay inside the stored 320x180 frame
   assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
      mask_valid_o |-> (mask_hcount_o < FRAME_W) && (mask_vcount_o < FRAME_H));

endmodule

//--- hw/center_of_mass.sv
`timescale 1ns/1ps

module center_of_mass import camera_pkg::*; (
   input  logic                clk_camera,
   input  logic                sys_rst_camera,
   input  logic                mask_valid_i,
   input  logic [HCOUNT_W-1:0] mask_hcount_i,
   input  logic [VCOUNT_W-1:0] mask_vcount_i,
   input  logic                mask_bit_i,
   output logic [HCOUNT_W-1:0] com_x_o,
   output logic [VCOUNT_W-1:0] com_y_o,
   output logic                com_valid_o
);

   // accumulators for the frame being received
   logic [SUM_W-1:0]         sum_x;
   logic [SUM_W-1:0]         sum_y;
   logic [CNT_W-1:0]         pix_cnt;
   // sums including the current pixel
   logic [SUM_W-1:0]         next_sum_x;
   logic [SUM_W-1:0]         next_sum_y;
   logic [CNT_W-1:0]         next_cnt;
   logic                     take;
   logic                     frame_end;
   // divider state, busy marks the divide phase
   logic                     busy;
   logic                     start;
   logic                     last;
   logic [$clog2(SUM_W)-1:0] bit_cnt;
   logic [CNT_W-1:0]         divisor;
   logic [CNT_W-1:0]         rem_x;
   logic [CNT_W-1:0]         rem_y;
   logic [SUM_W-1:0]         quo_x;
   logic [SUM_W-1:0]         quo_y;
   logic [CNT_W+SUM_W-1:0]   step_x;
   logic [CNT_W+SUM_W-1:0]   step_y;

   // one restoring step: shift in next dividend bit, subtract if it fits
   function automatic logic [CNT_W+SUM_W-1:0] div_step(
      input logic [CNT_W-1:0] rem,
      input logic [SUM_W-1:0] quo,
      input logic [CNT_W-1:0] den
   );
      logic [CNT_W:0] trial;
      logic [CNT_W:0] diff;
      trial = {rem, quo[SUM_W-1]};
      diff  = trial - {1'b0, den};
      if (trial >= {1'b0, den}) begin
         div_step = {diff[CNT_W-1:0], quo[SUM_W-2:0], 1'b1};
      end else begin
         div_step = {trial[CNT_W-1:0], quo[SUM_W-2:0], 1'b0};
      end
   endfunction

   always_comb begin
      take       = mask_valid_i && mask_bit_i;
      // last pixel of the frame is seen here directly
      frame_end  = mask_valid_i && (mask_hcount_i == HCOUNT_W'(FRAME_W - 1))
                   && (mask_vcount_i == VCOUNT_W'(FRAME_H - 1));
      next_sum_x = take ? sum_x + SUM_W'(mask_hcount_i) : sum_x;
      next_sum_y = take ? sum_y + SUM_W'(mask_vcount_i) : sum_y;
      next_cnt   = take ? pix_cnt + 1'b1 : pix_cnt;
      // empty frame never starts a division
      start      = frame_end && (next_cnt != '0);
      last       = busy && (bit_cnt == '0);
      step_x     = div_step(rem_x, quo_x, divisor);
      step_y     = div_step(rem_y, quo_y, divisor);
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         sum_x       <= '0;
         sum_y       <= '0;
         pix_cnt     <= '0;
         busy        <= 1'b0;
         com_valid_o <= 1'b0;
      end else begin
         // frame end hands the totals to the divider and starts afresh
         if (frame_end) begin
            sum_x   <= '0;
            sum_y   <= '0;
            pix_cnt <= '0;
         end else begin
            sum_x   <= next_sum_x;
            sum_y   <= next_sum_y;
            pix_cnt <= next_cnt;
         end
         if (start) begin
            busy <= 1'b1;
         end else if (last) begin
            busy <= 1'b0;
         end
         // done state lasts one cycle
         com_valid_o <= last;
      end
   end

   // both quotients share one divisor and one bit counter
   always_ff @(posedge clk_camera) begin
      if (start) begin
         divisor <= next_cnt;
         quo_x   <= next_sum_x;
         quo_y   <= next_sum_y;
         rem_x   <= '0;
         rem_y   <= '0;
         bit_cnt <= ($clog2(SUM_W))'(SUM_W - 1);
      end else if (busy) begin
         {rem_x, quo_x} <= step_x;
         {rem_y, quo_y} <= step_y;
         bit_cnt        <= bit_cnt - 1'b1;
      end
      // averages of in-frame coordinates fit the count widths
      if (last) begin
         com_x_o <= step_x[HCOUNT_W-1:0];
         com_y_o <= step_y[VCOUNT_W-1:0];
      end
   end

   // a new frame must not end before the previous division finished
   assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
      frame_end |-> !busy);

endmodule

//--- hw/video_mux.sv
`timescale 1ns/1ps

module video_mux import camera_pkg::*; (
   input  logic                 clk_camera,
   input  logic                 sys_rst_camera,
   input  logic [1:0]           display_choice_i,
   input  logic                 mask_valid_i,
   input  logic [HCOUNT_W-1:0]  mask_hcount_i,
   input  logic [VCOUNT_W-1:0]  mask_vcount_i,
   input  pixel_u               mask_pixel_i,
   input  logic                 mask_bit_i,
   input  logic [HCOUNT_W-1:0]  com_x_i,
   input  logic [VCOUNT_W-1:0]  com_y_i,
   input  logic                 com_valid_i,
   output logic                 fb_we_o,
   output logic [FB_ADDR_W-1:0] fb_waddr_o,
   output pixel_u               fb_wdata_o
);

   // centroid of the last frame that had masked pixels
   logic [HCOUNT_W-1:0] held_x;
   logic [VCOUNT_W-1:0] held_y;
   logic                on_cross;
   pixel_u              sel_pixel;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         held_x <= '0;
         held_y <= '0;
      end else if (com_valid_i) begin
         held_x <= com_x_i;
         held_y <= com_y_i;
      end
   end

   always_comb begin
      // crosshair is the full row and column through the centroid
      on_cross = (mask_hcount_i == held_x) || (mask_vcount_i == held_y);
      case (display_choice_i)
         MODE_CAMERA:    sel_pixel = mask_pixel_i;
         MODE_MASK:      sel_pixel.raw = mask_bit_i ? WHITE_PIXEL : 16'h0000;
         MODE_CROSSHAIR: sel_pixel.raw = on_cross ? WHITE_PIXEL : mask_pixel_i.raw;
         MODE_HIGHLIGHT: sel_pixel.raw = mask_bit_i ? RED_PIXEL : mask_pixel_i.raw;
      endcase
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         fb_we_o <= 1'b0;
      end else begin
         fb_we_o <= mask_valid_i;
      end
   end

   // row-major linear address into the 320-wide buffer
   always_ff @(posedge clk_camera) begin
      fb_waddr_o <= FB_ADDR_W'(mask_vcount_i) * FB_ADDR_W'(FRAME_W)
                    + FB_ADDR_W'(mask_hcount_i);
      fb_wdata_o <= sel_pixel;
   end

endmodule

//--- hw/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer import camera_pkg::*; (
   input  logic                 clk_camera,
   input  logic                 we_i,
   input  logic [FB_ADDR_W-1:0] waddr_i,
   input  pixel_u               wdata_i,
   input  logic [FB_ADDR_W-1:0] raddr_i,
   output pixel_u               rdata_o
);

   pixel_u mem [FB_DEPTH];
   // first read stage, memory latch
   pixel_u rd_q;

   always_ff @(posedge clk_camera) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // registered read plus output register, two cycles address to data
   always_ff @(posedge clk_camera) begin
      rd_q    <= mem[raddr_i];
      rdata_o <= rd_q;
   end

   // write side addresses come from in-frame counts only
   assert property (@(posedge clk_camera) we_i |-> (waddr_i < FB_DEPTH));

endmodule

//--- hw/frame_reader.sv
`timescale 1ns/1ps

module frame_reader import camera_pkg::*; (
   input  logic                 clk_camera,
   input  logic                 sys_rst_camera,
   input  logic [HCOUNT_W-1:0]  draw_hcount_i,
   input  logic [VCOUNT_W-1:0]  draw_vcount_i,
   input  pixel_u               rdata_i,
   output logic [FB_ADDR_W-1:0] raddr_o,
   output logic [7:0]           red_o,
   output logic [7:0]           green_o,
   output logic [7:0]           blue_o
);

   logic in_range;
   // in-range flag delayed to meet the buffer output
   logic range_q1;
   logic range_q2;
   logic range_q3;

   assign in_range = (draw_hcount_i < DRAW_W) && (draw_vcount_i < DRAW_H);

   // four drawing pixels per frame pixel in each direction
   // outside the raster, park on word 0 so the read stays in the array
   always_ff @(posedge clk_camera) begin
      if (in_range) begin
         raddr_o <= FB_ADDR_W'(draw_vcount_i >> SCALE_SHIFT) * FB_ADDR_W'(FRAME_W)
                    + FB_ADDR_W'(draw_hcount_i >> SCALE_SHIFT);
      end else begin
         raddr_o <= '0;
      end
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         range_q1 <= 1'b0;
         range_q2 <= 1'b0;
         range_q3 <= 1'b0;
         red_o    <= '0;
         green_o  <= '0;
         blue_o   <= '0;
      end else begin
         range_q1 <= in_range;
         range_q2 <= range_q1;
         range_q3 <= range_q2;
         // zero fill below each field, black when off raster
         red_o    <= range_q3 ? {rdata_i.rgb.red, 3'b000} : 8'h00;
         green_o  <= range_q3 ? {rdata_i.rgb.green, 2'b00} : 8'h00;
         blue_o   <= range_q3 ? {rdata_i.rgb.blue, 3'b000} : 8'h00;
      end
   end

endmodule

//--- hw/camera_tracker.sv
`timescale 1ns/1ps

module camera_tracker import camera_pkg::*; (
   input  logic                clk_camera,
   input  logic                sys_rst_camera,
   input  logic                pixel_valid_i,
   input  logic [HCOUNT_W-1:0] pixel_hcount_i,
   input  logic [VCOUNT_W-1:0] pixel_vcount_i,
   input  pixel_u              pixel_data_i,
   input  logic [1:0]          display_choice_i,
   input  logic [HCOUNT_W-1:0] draw_hcount_i,
   input  logic [VCOUNT_W-1:0] draw_vcount_i,
   output logic [HCOUNT_W-1:0] com_x_o,
   output logic [VCOUNT_W-1:0] com_y_o,
   output logic                com_valid_o,
   output logic [7:0]          red_o,
   output logic [7:0]          green_o,
   output logic [7:0]          blue_o
);

   // stage 1 outputs, shared by centroid and selector
   logic                 mask_valid;
   logic [HCOUNT_W-1:0]  mask_hcount;
   logic [VCOUNT_W-1:0]  mask_vcount;
   pixel_u               mask_pixel;
   logic                 mask_bit;
   // write port into the buffer
   logic                 fb_we;
   logic [FB_ADDR_W-1:0] fb_waddr;
   pixel_u               fb_wdata;
   // read port
   logic [FB_ADDR_W-1:0] fb_raddr;
   pixel_u               fb_rdata;

   mask_threshold u_mask (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .pixel_valid_i  (pixel_valid_i),
      .pixel_hcount_i (pixel_hcount_i),
      .pixel_vcount_i (pixel_vcount_i),
      .pixel_data_i   (pixel_data_i),
      .mask_valid_o   (mask_valid),
      .mask_hcount_o  (mask_hcount),
      .mask_vcount_o  (mask_vcount),
      .mask_pixel_o   (mask_pixel),
      .mask_bit_o     (mask_bit)
   );

   center_of_mass u_com (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .mask_valid_i   (mask_valid),
      .mask_hcount_i  (mask_hcount),
      .mask_vcount_i  (mask_vcount),
      .mask_bit_i     (mask_bit),
      .com_x_o        (com_x_o),
      .com_y_o        (com_y_o),
      .com_valid_o    (com_valid_o)
   );

   video_mux u_mux (
      .clk_camera       (clk_camera),
      .sys_rst_camera   (sys_rst_camera),
      .display_choice_i (display_choice_i),
      .mask_valid_i     (mask_valid),
      .mask_hcount_i    (mask_hcount),
      .mask_vcount_i    (mask_vcount),
      .mask_pixel_i     (mask_pixel),
      .mask_bit_i       (mask_bit),
      .com_x_i          (com_x_o),
      .com_y_i          (com_y_o),
      .com_valid_i      (com_valid_o),
      .fb_we_o          (fb_we),
      .fb_waddr_o       (fb_waddr),
      .fb_wdata_o       (fb_wdata)
   );

   frame_buffer u_fb (
      .clk_camera (clk_camera),
      .we_i       (fb_we),
      .waddr_i    (fb_waddr),
      .wdata_i    (fb_wdata),
      .raddr_i    (fb_raddr),
      .rdata_o    (fb_rdata)
   );

   frame_reader u_reader (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .draw_hcount_i  (draw_hcount_i),
      .draw_vcount_i  (draw_vcount_i),
      .rdata_i        (fb_rdata),
      .raddr_o        (fb_raddr),
      .red_o          (red_o),
      .green_o        (green_o),
      .blue_o         (blue_o)
   );

endmodule

//--- sim/camera_tracker_tb.sv
`timescale 1ns/1ps

module camera_tracker_tb import camera_pkg::*; ();

   logic                clk_camera;
   logic                sys_rst_camera;
   logic                pixel_valid_i;
   logic [HCOUNT_W-1:0] pixel_hcount_i;
   logic [VCOUNT_W-1:0] pixel_vcount_i;
   pixel_u              pixel_data_i;
   logic [1:0]          display_choice_i;
   logic [HCOUNT_W-1:0] draw_hcount_i;
   logic [VCOUNT_W-1:0] draw_vcount_i;
   logic [HCOUNT_W-1:0] com_x_o;
   logic [VCOUNT_W-1:0] com_y_o;
   logic                com_valid_o;
   logic [7:0]          red_o;
   logic [7:0]          green_o;
   logic [7:0]          blue_o;

   // reference model of the stored frame and the centroid path
   logic [15:0] fb_model [FB_DEPTH];
   int          sum_x;
   int          sum_y;
   int          pix_count;
   int          held_x;
   int          held_y;
   int          errors;
   int          checks;
   // expected colours of reads still in the 4-cycle pipeline
   logic [23:0] pending [$];

   camera_tracker uut (.*);

   always #10 clk_camera = ~clk_camera;

   task automatic compare_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
      end
   endtask

   // red window test on the 8-bit widened channel
   function automatic logic in_window(input logic [15:0] word);
      logic [7:0] red_wide;
      red_wide = {word[15:11], 3'b000};
      return (red_wide >= RED_LOWER) && (red_wide <= RED_UPPER);
   endfunction

   function automatic logic [15:0] stored_word(input logic [1:0] mode, input logic [15:0] word,
                                               input int h, input int v);
      logic masked;
      masked = in_window(word);
      case (mode)
         MODE_MASK:      return masked ? WHITE_PIXEL : 16'h0000;
         MODE_CROSSHAIR: return (h == held_x || v == held_y) ? WHITE_PIXEL : word;
         MODE_HIGHLIGHT: return masked ? RED_PIXEL : word;
         default:        return word;
      endcase
   endfunction

   // fields padded with zeros to 8 bits each
   function automatic logic [23:0] expand_colour(input logic [15:0] word);
      return {word[15:11], 3'b000, word[10:5], 2'b00, word[4:0], 3'b000};
   endfunction

   // about one pixel in ten lands in the window, none for an empty frame
   function automatic logic [15:0] random_pixel(input logic empty);
      int         r;
      logic [4:0] red;
      if (!empty && ($urandom % 10) == 0) begin
         red = 5'(20 + $urandom % 11);
      end else begin
         r   = $urandom % 21;
         red = (r == 20) ? 5'd31 : 5'(r);
      end
      return {red, 6'($urandom), 5'($urandom)};
   endfunction

   task automatic drive_frame(input logic [1:0] mode, input logic empty);
      int          gap;
      logic [15:0] word;
      sum_x     = 0;
      sum_y     = 0;
      pix_count = 0;
      @(negedge clk_camera);
      display_choice_i = mode;
      for (int v = 0; v < FRAME_H; v++) begin
         for (int h = 0; h < FRAME_W; h++) begin
            gap = (($urandom % 4) == 0) ? ($urandom % 4) : 0;
            repeat (gap) begin
               @(negedge clk_camera);
               pixel_valid_i = 1'b0;
            end
            word = random_pixel(empty);
            @(negedge clk_camera);
            pixel_valid_i     = 1'b1;
            pixel_hcount_i    = HCOUNT_W'(h);
            pixel_vcount_i    = VCOUNT_W'(v);
            pixel_data_i.raw  = word;
            fb_model[v * FRAME_W + h] = stored_word(mode, word, h, v);
            if (in_window(word)) begin
               sum_x += h;
               sum_y += v;
               pix_count++;
            end
         end
      end
      @(negedge clk_camera);
      pixel_valid_i = 1'b0;
   endtask

   // pulse is due within 32 cycles of the last pixel
   task automatic wait_centroid();
      int n;
      int exp_x;
      int exp_y;
      n = 1;
      while (!com_valid_o && n < 32) begin
         @(negedge clk_camera);
         n++;
      end
      exp_x = sum_x / pix_count;
      exp_y = sum_y / pix_count;
      if (!com_valid_o) begin
         errors++;
         $display("centroid pulse did not arrive within 32 cycles of the last pixel");
      end else begin
         compare_value("com_x_o", 32'(com_x_o), 32'(exp_x));
         compare_value("com_y_o", 32'(com_y_o), 32'(exp_y));
         @(negedge clk_camera);
         compare_value("com_valid_o", 32'(com_valid_o), 32'd0);
      end
      held_x = exp_x;
      held_y = exp_y;
   endtask

   task automatic expect_no_pulse();
      int n;
      n = 0;
      while (n < 64) begin
         @(negedge clk_camera);
         if (com_valid_o) begin
            errors++;
            $display("centroid pulse appeared after a frame with no masked pixels");
            n = 64;
         end
         n++;
      end
   endtask

   // one read per cycle, output checked against the read issued 4 cycles before
   task automatic issue_read(input int h, input int v, input logic [23:0] expected);
      logic [23:0] due;
      @(negedge clk_camera);
      if (pending.size() == 4) begin
         due = pending.pop_front();
         compare_value("red_o", 32'(red_o), 32'(due[23:16]));
         compare_value("green_o", 32'(green_o), 32'(due[15:8]));
         compare_value("blue_o", 32'(blue_o), 32'(due[7:0]));
      end
      draw_hcount_i = HCOUNT_W'(h);
      draw_vcount_i = VCOUNT_W'(v);
      pending.push_back(expected);
   endtask

   task automatic drain_reads();
      logic [23:0] due;
      while (pending.size() > 0) begin
         @(negedge clk_camera);
         due = pending.pop_front();
         compare_value("red_o", 32'(red_o), 32'(due[23:16]));
         compare_value("green_o", 32'(green_o), 32'(due[15:8]));
         compare_value("blue_o", 32'(blue_o), 32'(due[7:0]));
         draw_hcount_i = '1;
         draw_vcount_i = '1;
      end
   endtask

   task automatic read_back_frame();
      for (int v = 0; v < FRAME_H; v++) begin
         for (int h = 0; h < FRAME_W; h++) begin
            issue_read(h * 4, v * 4, expand_colour(fb_model[v * FRAME_W + h]));
         end
      end
      drain_reads();
   endtask

   // any of the 4x4 drawing positions over one frame pixel gives its colour
   task automatic check_scaling();
      int x;
      int y;
      repeat (200) begin
         x = $urandom % FRAME_W;
         y = $urandom % FRAME_H;
         repeat (4) begin
            issue_read(4 * x + $urandom % 4, 4 * y + $urandom % 4,
                       expand_colour(fb_model[y * FRAME_W + x]));
         end
      end
      drain_reads();
   endtask

   task automatic check_off_raster();
      issue_read(DRAW_W, 0, 24'h0);
      issue_read(0, DRAW_H, 24'h0);
      issue_read(DRAW_W, DRAW_H, 24'h0);
      repeat (100) begin
         issue_read(DRAW_W + $urandom % 768, $urandom % 1024, 24'h0);
         issue_read($urandom % 2048, DRAW_H + $urandom % 304, 24'h0);
      end
      drain_reads();
   endtask

   initial begin
      errors           = 0;
      checks           = 0;
      held_x           = 0;
      held_y           = 0;
      void'($urandom(32'h7c85));
      clk_camera       = 1'b0;
      sys_rst_camera   = 1'b1;
      pixel_valid_i    = 1'b0;
      pixel_hcount_i   = '0;
      pixel_vcount_i   = '0;
      pixel_data_i.raw = 16'h0000;
      display_choice_i = MODE_CAMERA;
      // park the read side off the raster so colours stay black
      draw_hcount_i    = '1;
      draw_vcount_i    = '1;

      // outputs quiet during reset and shortly after release
      for (int i = 0; i < 24; i++) begin
         @(negedge clk_camera);
         if (i == 15) begin
            sys_rst_camera = 1'b0;
         end
         compare_value("com_valid_o", 32'(com_valid_o), 32'd0);
         compare_value("red_o", 32'(red_o), 32'd0);
         compare_value("green_o", 32'(green_o), 32'd0);
         compare_value("blue_o", 32'(blue_o), 32'd0);
      end

      drive_frame(MODE_CAMERA, 1'b0);
      wait_centroid();
      read_back_frame();

      drive_frame(MODE_MASK, 1'b0);
      wait_centroid();
      read_back_frame();

      drive_frame(MODE_HIGHLIGHT, 1'b0);
      wait_centroid();
      read_back_frame();

      // empty frame leaves the held centroid alone
      drive_frame(MODE_MASK, 1'b1);
      expect_no_pulse();
      read_back_frame();

      // crosshair drawn from the centroid of the highlight-mode frame
      drive_frame(MODE_CROSSHAIR, 1'b0);
      wait_centroid();
      read_back_frame();
      check_scaling();
      check_off_raster();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- camera_tracker.f
include/camera_pkg.sv
hw/mask_threshold.sv
hw/center_of_mass.sv
hw/video_mux.sv
hw/frame_buffer.sv
hw/frame_reader.sv
hw/camera_tracker.sv
sim/camera_tracker_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module camera_tracker_tb \
   -f camera_tracker.f -o camera_tracker_sim \
   && ./obj_dir/camera_tracker_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
   && exit 0 \
   || exit 1
